//--- audio_core_props.sv
/*
 * Audio core protocol assertions
 * Sender credits, output valid timing and buffer pops
 */
`timescale 1ns/1ps

module audio_core_props #(
	parameter int PCM_DEPTH = sys_audio_pkg::PCM_DEPTH_DEF
) (
	input logic clk_sys,
	input logic resetd,
	input logic i_pcm_valid,
	input logic i_pcm_credit,
	input logic i_sample_tick,
	input logic i_audio_valid
);

	// Credits held by the PCM sender
	int credits;

	always_ff @(posedge clk_sys) begin
		if (resetd)
			credits <= PCM_DEPTH;
		else
			credits <= credits - int'(i_pcm_valid) + int'(i_pcm_credit);
	end

	////////////////////////////////////////
	a_push_needs_credit: assert property (@(posedge clk_sys) disable iff (resetd)
		i_pcm_valid |-> credits != 0)
		else $error("PCM push with no credit left");

	a_valid_delay: assert property (@(posedge clk_sys) disable iff (resetd)
		i_audio_valid == $past(i_sample_tick, 5))
		else $error("Output valid is not the tick delayed by 5 cycles");

	// Pairs waiting in the buffer are the credits the sender has spent
	a_no_pop_empty: assert property (@(posedge clk_sys) disable iff (resetd)
		i_pcm_credit |-> credits < PCM_DEPTH)
		else $error("Buffer popped while empty");

endmodule

bind audio_core_top audio_core_props #(
	.PCM_DEPTH (PCM_DEPTH)
) audio_core_props_i (
	.clk_sys       (clk_sys),
	.resetd        (resetd),
	.i_pcm_valid   (i_pcm_valid),
	.i_pcm_credit  (o_pcm_credit),
	.i_sample_tick (i_sample_tick),
	.i_audio_valid (o_audio_valid)
);

//--- audio_core_top.sv
/*
 * Audio core top level
 * Host command decoder, PCM buffer and mixer.
 * Every popped pair hands one credit back to the PCM sender.
 */
`timescale 1ns/1ps

module audio_core_top #(
	parameter int PCM_DEPTH = sys_audio_pkg::PCM_DEPTH_DEF
) (
	input  logic                    clk_sys,
	input  logic                    resetd,

	input  logic                    i_io_uio,
	input  logic                    i_io_strobe,
	input  sys_audio_pkg::io_word_t i_io_din,

	input  logic                    i_pcm_valid,
	input  sys_audio_pkg::sample_t  i_pcm_l,
	input  sys_audio_pkg::sample_t  i_pcm_r,
	output logic                    o_pcm_credit,

	input  logic                    i_sample_tick,
	input  sys_audio_pkg::sample_t  i_core_l,
	input  sys_audio_pkg::sample_t  i_core_r,
	input  logic                    i_core_signed,
	output sys_audio_pkg::sample_t  o_audio_l,
	output sys_audio_pkg::sample_t  o_audio_r,
	output logic                    o_audio_valid
);

	import sys_audio_pkg::*;

	att_t    att;
	mix_t    mix;
	sample_t fifo_l;
	sample_t fifo_r;
	logic    fifo_empty;

	host_cmd_decoder host_cmd_decoder_i (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_att       (att),
		.o_mix       (mix)
	);

	// Credit pulse is the pop itself
	pcm_fifo #(
		.PCM_DEPTH (PCM_DEPTH)
	) pcm_fifo_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_push   (i_pcm_valid),
		.i_data_l (i_pcm_l),
		.i_data_r (i_pcm_r),
		.i_pop    (o_pcm_credit),
		.o_data_l (fifo_l),
		.o_data_r (fifo_r),
		.o_empty  (fifo_empty)
	);

	audio_mixer audio_mixer_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_sample_tick (i_sample_tick),
		.i_empty       (fifo_empty),
		.i_fifo_l      (fifo_l),
		.i_fifo_r      (fifo_r),
		.i_core_l      (i_core_l),
		.i_core_r      (i_core_r),
		.i_core_signed (i_core_signed),
		.i_att         (att),
		.i_mix         (mix),
		.o_pop         (o_pcm_credit),
		.o_audio_l     (o_audio_l),
		.o_audio_r     (o_audio_r),
		.o_audio_valid (o_audio_valid)
	);

endmodule

//--- audio_mixer.sv
/*
 * Stereo audio mixer
 * Pops one PCM pair per sample tick and runs both channels in
 * lockstep, flagging the result five cycles later
 */
`timescale 1ns/1ps

module audio_mixer (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_sample_tick,
	input  logic                   i_empty,
	input  sys_audio_pkg::sample_t i_fifo_l,
	input  sys_audio_pkg::sample_t i_fifo_r,
	input  sys_audio_pkg::sample_t i_core_l,
	input  sys_audio_pkg::sample_t i_core_r,
	input  logic                   i_core_signed,
	input  sys_audio_pkg::att_t    i_att,
	input  sys_audio_pkg::mix_t    i_mix,
	output logic                   o_pop,
	output sys_audio_pkg::sample_t o_audio_l,
	output sys_audio_pkg::sample_t o_audio_r,
	output logic                   o_audio_valid
);

	import sys_audio_pkg::*;

	localparam int PIPE_DEPTH = 5;

	sample_t               lin_l;
	sample_t               lin_r;
	sample_t               pre_l;
	sample_t               pre_r;
	logic [PIPE_DEPTH-1:0] vld_sr;

	// Starved buffer gives silence for that tick
	assign o_pop = i_sample_tick & ~i_empty;
	assign lin_l = o_pop ? i_fifo_l : '0;
	assign lin_r = o_pop ? i_fifo_r : '0;

	always_ff @(posedge clk_sys) begin
		if (resetd)
			vld_sr <= '0;
		else
			vld_sr <= {vld_sr[PIPE_DEPTH-2:0], i_sample_tick};
	end

	assign o_audio_valid = vld_sr[PIPE_DEPTH-1];

	////////////////////////////////////////
	// Channels, pre-outputs crossed
	////////////////////////////////////////

	mix_channel mix_l_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_adv         (i_sample_tick),
		.i_core        (i_core_l),
		.i_linux       (lin_l),
		.i_pre_in      (pre_r),
		.i_core_signed (i_core_signed),
		.i_mix         (i_mix),
		.i_att         (i_att),
		.o_pre_out     (pre_l),
		.o_out         (o_audio_l)
	);

	mix_channel mix_r_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_adv         (i_sample_tick),
		.i_core        (i_core_r),
		.i_linux       (lin_r),
		.i_pre_in      (pre_l),
		.i_core_signed (i_core_signed),
		.i_mix         (i_mix),
		.i_att         (i_att),
		.o_pre_out     (pre_r),
		.o_out         (o_audio_r)
	);

endmodule

//--- host_cmd_decoder.sv
/*
 * Host command decoder
 * First strobed word of a frame is the command, the next one its data.
 * Keeps the volume attenuation and the stereo mix mode registers.
 */
`timescale 1ns/1ps

module host_cmd_decoder (
	input  logic                    clk_sys,
	input  logic                    resetd,
	input  logic                    i_io_uio,
	input  logic                    i_io_strobe,
	input  sys_audio_pkg::io_word_t i_io_din,
	output sys_audio_pkg::att_t     o_att,
	output sys_audio_pkg::mix_t     o_mix
);

	import sys_audio_pkg::*;

	dec_state_t state;
	cmd_t       cmd;

	// First data word of the frame already taken
	logic       data_done;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state     <= IDLE;
			cmd       <= '0;
			data_done <= 1'b0;
			o_att     <= '0;
			o_mix     <= '0;
		end else if (!i_io_uio) begin
			// Frame closed, strobes are ignored
			state <= IDLE;
		end else begin
			case (state)
				IDLE,
				WAIT_CMD: begin
					if (i_io_strobe) begin
						cmd       <= i_io_din[7:0];
						data_done <= 1'b0;
						state     <= DATA;
					end else begin
						state <= WAIT_CMD;
					end
				end

				DATA: begin
					// Later words of the frame fall through here untouched
					if (i_io_strobe && !data_done) begin
						data_done <= 1'b1;
						case (cmd)
							CMD_VOL_ATT:   o_att <= i_io_din[4:0];
							CMD_AUDIO_MIX: o_mix <= i_io_din[1:0];
							default: ;
						endcase
					end
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

//--- mix_channel.sv
/*
 * One audio mixing channel
 * Five stages: capture, sum with host PCM, cross-feed,
 * attenuation and clamp to 16 bits
 */
`timescale 1ns/1ps

module mix_channel (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_adv,
	input  sys_audio_pkg::sample_t i_core,
	input  sys_audio_pkg::sample_t i_linux,
	input  sys_audio_pkg::sample_t i_pre_in,
	input  logic                   i_core_signed,
	input  sys_audio_pkg::mix_t    i_mix,
	input  sys_audio_pkg::att_t    i_att,
	output sys_audio_pkg::sample_t o_pre_out,
	output sys_audio_pkg::sample_t o_out
);

	import sys_audio_pkg::*;

	// Valid bits travelling beside stages 1..4
	logic [3:0]   stg_vld;

	wide_sample_t cap_core;
	sample_t      cap_lin;
	wide_sample_t sum_q;
	wide_sample_t xf_q;
	wide_sample_t att_q;

	// Half of the sum, feeds the other channel's cross-feed
	assign o_pre_out = sum_q[16:1];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			stg_vld  <= '0;
			cap_core <= '0;
			cap_lin  <= '0;
			sum_q    <= '0;
			xf_q     <= '0;
			att_q    <= '0;
			o_out    <= '0;
		end else begin
			stg_vld <= {stg_vld[2:0], i_adv};

			////////////////////////////////////////
			// Capture
			if (i_adv) begin
				// Unsigned core audio is halved to sit in the signed range
				cap_core <= i_core_signed ? {i_core[15], i_core} : {2'b00, i_core[15:1]};
				cap_lin  <= i_linux;
			end

			// Sum
			if (stg_vld[0])
				sum_q <= cap_core + {cap_lin[15], cap_lin};

			////////////////////////////////////////
			// Cross-feed
			if (stg_vld[1]) begin
				case (i_mix)
					2'd1: xf_q <= $signed(sum_q) - ($signed(sum_q) >>> 3)
						+ ($signed({i_pre_in[15], i_pre_in}) >>> 2);
					2'd2: xf_q <= $signed(sum_q) - ($signed(sum_q) >>> 2)
						+ ($signed({i_pre_in[15], i_pre_in}) >>> 1);
					2'd3: xf_q <= $signed(sum_q) - ($signed(sum_q) >>> 1)
						+ $signed({i_pre_in[15], i_pre_in});
					default: xf_q <= sum_q;
				endcase
			end

			// Attenuate or mute
			if (stg_vld[2]) begin
				if (i_att[4])
					att_q <= '0;
				else
					att_q <= $signed(xf_q) >>> i_att[3:0];
			end

			// Saturate when the headroom bit disagrees with bit 15
			if (stg_vld[3])
				o_out <= (att_q[16] ^ att_q[15]) ? {att_q[16], {15{att_q[15]}}} : att_q[15:0];
		end
	end

endmodule

//--- pcm_fifo.sv
/*
 * Stereo PCM buffer
 * Circular buffer of left/right pairs filled by the host stream.
 * Sender flow control is by credits, so no full flag leaves here.
 */
`timescale 1ns/1ps

module pcm_fifo #(
	parameter int PCM_DEPTH = sys_audio_pkg::PCM_DEPTH_DEF
) (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_push,
	input  sys_audio_pkg::sample_t i_data_l,
	input  sys_audio_pkg::sample_t i_data_r,
	input  logic                   i_pop,
	output sys_audio_pkg::sample_t o_data_l,
	output sys_audio_pkg::sample_t o_data_r,
	output logic                   o_empty
);

	import sys_audio_pkg::*;

	// Depth must be a power of two so the pointers wrap by themselves
	localparam int AW = $clog2(PCM_DEPTH);

	sample_t mem_l [PCM_DEPTH];
	sample_t mem_r [PCM_DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          full;
	logic          do_push;
	logic          do_pop;

	assign o_empty = (count == '0);
	assign full    = (count == (AW+1)'(PCM_DEPTH));
	assign do_push = i_push & ~full;
	assign do_pop  = i_pop & ~o_empty;

	// Head of the buffer, read without a register
	assign o_data_l = mem_l[rd_ptr];
	assign o_data_r = mem_r[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			mem_l[wr_ptr] <= i_data_l;
			mem_r[wr_ptr] <= i_data_r;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the audio core testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_audio_core \
	-f tb.f -o Vtb_audio_core > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
# A simulator abort counts as a failed run
./obj_dir/Vtb_audio_core > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

//--- sys_audio_pkg.sv
/*
 * Audio core shared definitions
 * Sample and setting widths, host command codes and the
 * command decoder state encoding
 */
package sys_audio_pkg;

	////////////////////////////////////////
	// Audio data
	////////////////////////////////////////

	// Two's complement PCM sample
	typedef logic [15:0] sample_t;

	// Sum with one bit of headroom
	typedef logic [16:0] wide_sample_t;

	// Bit 4 mutes, bits 3:0 are the right shift
	typedef logic [4:0] att_t;

	// Stereo cross-feed, 0 is plain stereo
	typedef logic [1:0] mix_t;

	////////////////////////////////////////
	// Host command port
	////////////////////////////////////////

	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  cmd_t;

	localparam cmd_t CMD_VOL_ATT   = 8'h26;
	localparam cmd_t CMD_AUDIO_MIX = 8'h29;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_CMD,
		DATA
	} dec_state_t;

	// PCM buffer depth in stereo pairs
	localparam int PCM_DEPTH_DEF = 8;

endpackage

//--- tb.f
sys_audio_pkg.sv
host_cmd_decoder.sv
pcm_fifo.sv
mix_channel.sv
audio_mixer.sv
audio_core_top.sv
audio_core_props.sv
tb_audio_core.sv

//--- tb_audio_core.sv
/*
 * Audio core testbench
 * Random host commands, credit-based PCM pushes, sample ticks and
 * core audio, checked against a reference model of the mixer
 */
`timescale 1ns/1ps

module tb_audio_core;

	import sys_audio_pkg::*;

	localparam int PCM_DEPTH = 8;
	localparam int SEED      = 16266;
	localparam int NUM_TICKS = 600;
	localparam int WD_CYCLES = NUM_TICKS * 20 + 2000;
	localparam int MAX_CYC   = WD_CYCLES + 16;
	localparam int LATENCY   = 5;

	typedef struct packed {
		int      t;
		sample_t core_l;
		sample_t core_r;
		logic    sgn;
		sample_t lin_l;
		sample_t lin_r;
	} tick_rec_t;

	logic     clk_sys = 1'b0;
	logic     resetd;
	logic     io_uio;
	logic     io_strobe;
	io_word_t io_din;
	logic     pcm_valid;
	sample_t  pcm_l;
	sample_t  pcm_r;
	logic     pcm_credit;
	logic     sample_tick;
	sample_t  core_l;
	sample_t  core_r;
	logic     core_signed;
	sample_t  audio_l;
	sample_t  audio_r;
	logic     audio_valid;

	// Model state
	att_t        m_att;
	mix_t        m_mix;
	cmd_t        m_cmd;
	logic        m_has_cmd;
	logic        m_data_done;
	att_t        att_hist [MAX_CYC];
	mix_t        mix_hist [MAX_CYC];
	sample_t     pcm_ql [$];
	sample_t     pcm_qr [$];
	tick_rec_t   pend_q [$];
	logic [17:0] frame_q [$];
	logic        exp_pop;
	int          credits;
	int          pushes;
	int          model_pops;
	int          credit_pulses;
	int          valid_seen;
	int          ticks_sent;
	int          err_sample;
	int          err_bit;
	int          err_count;
	int          err_other;

	audio_core_top #(
		.PCM_DEPTH (PCM_DEPTH)
	) audio_core_top_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_io_uio      (io_uio),
		.i_io_strobe   (io_strobe),
		.i_io_din      (io_din),
		.i_pcm_valid   (pcm_valid),
		.i_pcm_l       (pcm_l),
		.i_pcm_r       (pcm_r),
		.o_pcm_credit  (pcm_credit),
		.i_sample_tick (sample_tick),
		.i_core_l      (core_l),
		.i_core_r      (core_r),
		.i_core_signed (core_signed),
		.o_audio_l     (audio_l),
		.o_audio_r     (audio_r),
		.o_audio_valid (audio_valid)
	);

	always #4 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_sample(input sample_t got, input sample_t exp, input string what);
		if (got !== exp) begin
			err_sample++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			err_bit++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			err_count++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////
	// Reference arithmetic
	////////////////////////////////////////

	// Signed core audio as is, unsigned halved
	function automatic int core_term(input sample_t s, input logic sgn);
		if (sgn)
			return int'($signed(s));
		return int'(s) / 2;
	endfunction

	function automatic int cross_feed(input int sum, input int pre_other, input mix_t mode);
		case (mode)
			2'd1: return sum - (sum >>> 3) + (pre_other >>> 2);
			2'd2: return sum - (sum >>> 2) + (pre_other >>> 1);
			2'd3: return sum - (sum >>> 1) + pre_other;
			default: return sum;
		endcase
	endfunction

	function automatic sample_t finish_sample(input int xf, input att_t att);
		int v;
		v = att[4] ? 0 : (xf >>> att[3:0]);
		if (v > 32767)
			v = 32767;
		if (v < -32768)
			v = -32768;
		return sample_t'(v);
	endfunction

	// Full-scale values now and then
	function automatic sample_t rand_sample();
		case ($urandom % 8)
			0: return 16'h7fff;
			1: return 16'h8000;
			2: return 16'hffff;
			default: return sample_t'($urandom);
		endcase
	endfunction

	////////////////////////////////////////
	// Host command frames
	////////////////////////////////////////

	task automatic queue_frame();
		int       kind;
		cmd_t     cmd;
		io_word_t data;
		kind = $urandom % 6;
		data = io_word_t'($urandom);
		if (kind == 0) begin
			// Stray strobe with the frame closed
			frame_q.push_back({2'b01, data});
			return;
		end
		if (kind == 1)
			cmd = cmd_t'(8'h10 + ($urandom % 16));
		else if (kind < 4)
			cmd = CMD_VOL_ATT;
		else
			cmd = CMD_AUDIO_MIX;
		if (cmd == CMD_VOL_ATT) begin
			data[4] = (($urandom % 5) == 0);
			data[3:0] = (($urandom % 4) == 0) ? 4'($urandom) : 4'($urandom % 3);
		end
		frame_q.push_back({2'b10, 16'h0000});
		frame_q.push_back({2'b11, io_word_t'($urandom) & 16'hff00 | 16'(cmd)});
		repeat ($urandom % 3)
			frame_q.push_back({2'b10, io_word_t'($urandom)});
		frame_q.push_back({2'b11, data});
		// Extra word that the decoder must not use
		if (($urandom % 2) == 1)
			frame_q.push_back({2'b11, io_word_t'($urandom)});
		frame_q.push_back({2'b00, 16'h0000});
	endtask

	// Decoder rules applied to one clocked bus word
	task automatic decode_word(input logic uio, input logic strobe, input io_word_t din);
		if (!uio) begin
			m_has_cmd = 1'b0;
		end else if (!m_has_cmd) begin
			if (strobe) begin
				m_cmd       = din[7:0];
				m_has_cmd   = 1'b1;
				m_data_done = 1'b0;
			end
		end else if (strobe && !m_data_done) begin
			m_data_done = 1'b1;
			if (m_cmd == CMD_VOL_ATT)
				m_att = din[4:0];
			else if (m_cmd == CMD_AUDIO_MIX)
				m_mix = din[1:0];
		end
	endtask

	////////////////////////////////////////
	// Per-cycle stimulus and checks
	////////////////////////////////////////

	task automatic drive_cycle(input int n);
		logic [17:0] fw;
		logic        stim;
		tick_rec_t   rec;
		stim = (ticks_sent < NUM_TICKS);
		if (frame_q.size() == 0 && stim && ($urandom % 40) == 0)
			queue_frame();
		fw = (frame_q.size() > 0) ? frame_q.pop_front() : 18'h0;
		io_uio    = fw[17];
		io_strobe = fw[16];
		io_din    = fw[15:0];
		decode_word(fw[17], fw[16], fw[15:0]);
		att_hist[n] = m_att;
		mix_hist[n] = m_mix;

		// First tick meets an empty buffer
		sample_tick = (n == 0) || (stim && ($urandom % 2) == 1);
		core_l      = rand_sample();
		core_r      = rand_sample();
		core_signed = ($urandom % 2) == 1;
		exp_pop     = sample_tick && (pcm_ql.size() > 0);
		if (sample_tick) begin
			rec.t      = n;
			rec.core_l = core_l;
			rec.core_r = core_r;
			rec.sgn    = core_signed;
			rec.lin_l  = exp_pop ? pcm_ql.pop_front() : 16'h0000;
			rec.lin_r  = exp_pop ? pcm_qr.pop_front() : 16'h0000;
			pend_q.push_back(rec);
			ticks_sent++;
		end

		pcm_valid = stim && (credits > 0) && (($urandom % 3) != 0);
		pcm_l     = rand_sample();
		pcm_r     = rand_sample();
		if (pcm_valid) begin
			pcm_ql.push_back(pcm_l);
			pcm_qr.push_back(pcm_r);
			credits--;
			pushes++;
		end
		if (exp_pop) begin
			credits++;
			model_pops++;
		end
	endtask

	task automatic check_outputs(input int p);
		tick_rec_t r;
		int        sum_l;
		int        sum_r;
		mix_t      mode;
		att_t      att;
		logic      exp_valid;
		exp_valid = (pend_q.size() > 0) && (pend_q[0].t == p - (LATENCY - 1));
		check_bit(audio_valid, exp_valid, "o_audio_valid");
		if (audio_valid === 1'b1)
			valid_seen++;
		if (exp_valid) begin
			r     = pend_q.pop_front();
			sum_l = core_term(r.core_l, r.sgn) + int'($signed(r.lin_l));
			sum_r = core_term(r.core_r, r.sgn) + int'($signed(r.lin_r));
			// Settings as seen by the cross-feed and attenuation stages
			mode  = mix_hist[r.t + 1];
			att   = att_hist[r.t + 2];
			check_sample(audio_l, finish_sample(cross_feed(sum_l, sum_r >>> 1, mode), att),
				"o_audio_l");
			check_sample(audio_r, finish_sample(cross_feed(sum_r, sum_l >>> 1, mode), att),
				"o_audio_r");
		end
	endtask

	initial begin
		repeat (WD_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles before the test finished", WD_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int n;
		int drain;
		int seed_val;
		seed_val    = $urandom(SEED);
		resetd      = 1'b1;
		io_uio      = 1'b0;
		io_strobe   = 1'b0;
		io_din      = '0;
		pcm_valid   = 1'b0;
		pcm_l       = '0;
		pcm_r       = '0;
		sample_tick = 1'b0;
		core_l      = '0;
		core_r      = '0;
		core_signed = 1'b0;
		m_att       = '0;
		m_mix       = '0;
		m_cmd       = '0;
		m_has_cmd   = 1'b0;
		m_data_done = 1'b0;
		credits     = PCM_DEPTH;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		resetd = 1'b0;
		check_bit(audio_valid, 1'b0, "o_audio_valid after reset");
		check_bit(pcm_credit, 1'b0, "o_pcm_credit after reset");

		n     = 0;
		drain = 0;
		while (drain < LATENCY + 8) begin
			drive_cycle(n);
			#1;
			check_bit(pcm_credit, exp_pop, "o_pcm_credit");
			if (pcm_credit === 1'b1)
				credit_pulses++;
			if (credit_pulses > pushes) begin
				err_other++;
				$display("More credit pulses (%0d) than pushed pairs (%0d)", credit_pulses, pushes);
			end
			@(negedge clk_sys);
			check_outputs(n);
			n++;
			if (ticks_sent >= NUM_TICKS)
				drain++;
		end

		check_count(credit_pulses, model_pops, "credit pulse count");
		check_count(valid_seen, ticks_sent, "output valid count");
		if (pend_q.size() != 0) begin
			err_other++;
			$display("%0d expected output pairs never appeared", pend_q.size());
		end
		$display("Errors: sample %0d, bit %0d, count %0d, other %0d",
			err_sample, err_bit, err_count, err_other);
		if (err_sample + err_bit + err_count + err_other == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
